//--- exec_top.f
+incdir+include
hw/exec_pkg.sv
hw/inst_decoder.sv
hw/gpr_file.sv
hw/csr_file.sv
hw/alu.sv
hw/exu.sv
hw/exec_top.sv
testbench/exec_top_tb.sv

//--- hw/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu
    import exec_pkg::*;
(
    input  alu_op_e op,
    input  xlen_t   a,
    input  xlen_t   b,
    input  xlen_t   c,
    input  xlen_t   d,
    output xlen_t   result,
    output xlen_t   cond
);

    logic taken;

    always_comb begin
        case (op)
            alu_sub:      result = a - b;
            alu_sll:      result = a << b[4:0];
            alu_slt:      result = {31'b0, $signed(a) < $signed(b)};
            alu_sltu:     result = {31'b0, a < b};
            alu_xor:      result = a ^ b;
            alu_srl:      result = a >> b[4:0];
            alu_sra:      result = xlen_t'($signed(a) >>> b[4:0]);
            alu_or:       result = a | b;
            alu_and:      result = a & b;
            alu_lui_pass: result = b;
            // branches also add, which gives the target
            default:      result = a + b;
        endcase
    end

    always_comb begin
        case (op)
            alu_beq:  taken = c == d;
            alu_bne:  taken = c != d;
            alu_blt:  taken = $signed(c) < $signed(d);
            alu_bge:  taken = $signed(c) >= $signed(d);
            alu_bltu: taken = c < d;
            alu_bgeu: taken = c >= d;
            default:  taken = 1'b0;
        endcase
    end

    assign cond = {31'b0, taken};

endmodule

`default_nettype wire

//--- hw/csr_file.sv
`timescale 1ns/1ns
`default_nettype none

module csr_file
    import exec_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  csr_sel_e   sel,
    input  csr_write_t csr_write,
    output xlen_t      mtvec,
    output xlen_t      mepc,
    output xlen_t      rdata
);

    assign rdata = (sel == csr_mepc) ? mepc : mtvec;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtvec <= '0;
            mepc  <= '0;
        end else if (csr_write.ecall) begin
            mepc <= csr_write.epc;
        end else if (csr_write.en) begin
            // csrrs arrives here already merged with the old value
            if (csr_write.sel == csr_mepc) begin
                mepc <= csr_write.data;
            end else begin
                mtvec <= csr_write.data;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/exec_pkg.sv
`default_nettype none

package exec_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] inst_t;

    typedef enum logic [4:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra,
        alu_or, alu_and, alu_lui_pass,
        alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu
    } alu_op_e;

    typedef enum logic [1:0] {mem_byte, mem_half, mem_word} mem_size_e;
    typedef enum logic [1:0] {csr_none, csr_rw, csr_rs} csr_op_e;
    typedef enum logic       {csr_mtvec, csr_mepc} csr_sel_e;
    typedef enum logic       {exu_idle, exu_busy} exu_state_e;

    typedef struct packed {
        xlen_t     imm;
        alu_op_e   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      is_jump;
        // branch target comes from result, the compare from cond
        logic      is_branch;
        logic      mem_load;
        logic      mem_store;
        mem_size_e mem_size;
        reg_idx_t  rd;
        logic      rd_we;
        logic      ecall;
        logic      mret;
        csr_op_e   csr_op;
        csr_sel_e  csr_sel;
        logic      ebreak;
        logic      illegal;
    } exu_ctrl_t;

    typedef struct packed {
        xlen_t src1;
        xlen_t src2;
        xlen_t mtvec;
        xlen_t mepc;
        xlen_t csr_rdata;
    } exu_operands_t;

    typedef struct packed {
        xlen_t     addr_or_result;
        xlen_t     store_data;
        logic      load;
        logic      store;
        mem_size_e size;
        reg_idx_t  rd;
    } lsu_req_t;

    typedef struct packed {
        logic     en;
        csr_sel_e sel;
        xlen_t    data;
        logic     ecall;
        xlen_t    epc;
    } csr_write_t;

    localparam xlen_t reset_pc = 32'h8000_0000;

endpackage

`default_nettype wire

//--- hw/exec_top.sv
`timescale 1ns/1ns
`default_nettype none

module exec_top
    import exec_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  inst_t    inst,
    input  xlen_t    pc,
    input  logic     lsu_ready,
    input  logic     wb_valid,
    input  reg_idx_t wb_rd,
    input  xlen_t    wb_data,
    output logic     exu_valid,
    output lsu_req_t lsu_req,
    output xlen_t    dnpc,
    output logic     halt,
    output logic     illegal
);

    exu_ctrl_t     ctrl;
    exu_operands_t ops;
    reg_idx_t      rs1;
    reg_idx_t      rs2;
    xlen_t         rdata1;
    xlen_t         rdata2;
    xlen_t         mtvec;
    xlen_t         mepc;
    xlen_t         csr_rdata;
    logic          gpr_we;
    reg_idx_t      gpr_waddr;
    xlen_t         gpr_wdata;
    csr_write_t    csr_write;

    assign ops = '{src1: rdata1, src2: rdata2, mtvec: mtvec, mepc: mepc, csr_rdata: csr_rdata};

    inst_decoder u_decoder (
        .inst (inst),
        .ctrl (ctrl),
        .rs1  (rs1),
        .rs2  (rs2)
    );

    gpr_file u_gpr (
        .clk       (clk),
        .rst       (rst),
        .rs1       (rs1),
        .rs2       (rs2),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .exu_we    (gpr_we),
        .exu_waddr (gpr_waddr),
        .exu_wdata (gpr_wdata),
        .wb_we     (wb_valid),
        .wb_waddr  (wb_rd),
        .wb_wdata  (wb_data)
    );

    csr_file u_csr (
        .clk       (clk),
        .rst       (rst),
        .sel       (ctrl.csr_sel),
        .csr_write (csr_write),
        .mtvec     (mtvec),
        .mepc      (mepc),
        .rdata     (csr_rdata)
    );

    exu u_exu (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .pc        (pc),
        .ctrl      (ctrl),
        .ops       (ops),
        .lsu_ready (lsu_ready),
        .exu_valid (exu_valid),
        .lsu_req   (lsu_req),
        .dnpc      (dnpc),
        .halt      (halt),
        .illegal   (illegal),
        .gpr_we    (gpr_we),
        .gpr_waddr (gpr_waddr),
        .gpr_wdata (gpr_wdata),
        .csr_write (csr_write)
    );

endmodule

`default_nettype wire

//--- hw/exu.sv
`timescale 1ns/1ns
`default_nettype none

module exu
    import exec_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          in_valid,
    output logic          in_ready,
    input  xlen_t         pc,
    input  exu_ctrl_t     ctrl,
    input  exu_operands_t ops,
    input  logic          lsu_ready,
    output logic          exu_valid,
    output lsu_req_t      lsu_req,
    output xlen_t         dnpc,
    output logic          halt,
    output logic          illegal,
    output logic          gpr_we,
    output reg_idx_t      gpr_waddr,
    output xlen_t         gpr_wdata,
    output csr_write_t    csr_write
);

    exu_state_e    state;
    xlen_t         pc_r;
    exu_ctrl_t     ctrl_r;
    exu_operands_t ops_r;
    xlen_t         alu_result;
    xlen_t         alu_cond;
    xlen_t         snpc;
    xlen_t         next_pc;
    xlen_t         result;
    logic          done;

    assign in_ready = state == exu_idle;
    assign done     = state == exu_busy && lsu_ready;

    alu u_alu (
        .op     (ctrl_r.alu_op),
        .a      (ctrl_r.src1_is_pc ? pc_r : ops_r.src1),
        .b      (ctrl_r.src2_is_imm ? ctrl_r.imm : ops_r.src2),
        .c      (ops_r.src1),
        .d      (ops_r.src2),
        .result (alu_result),
        .cond   (alu_cond)
    );

    assign snpc = pc_r + 32'd4;

    // target bit 0 is cleared for jalr, other targets are already even
    always_comb begin
        if (ctrl_r.ecall) begin
            next_pc = ops_r.mtvec;
        end else if (ctrl_r.mret) begin
            next_pc = ops_r.mepc;
        end else if (ctrl_r.is_jump || (ctrl_r.is_branch && alu_cond[0])) begin
            next_pc = {alu_result[31:1], 1'b0};
        end else begin
            next_pc = snpc;
        end
    end

    assign result = ctrl_r.is_jump ? snpc :
                    (ctrl_r.csr_op != csr_none) ? ops_r.csr_rdata : alu_result;

    // the register writes commit at the completion edge itself
    // loads reach the register file through the writeback port
    assign gpr_we    = done && ctrl_r.rd_we && !ctrl_r.mem_load;
    assign gpr_waddr = ctrl_r.rd;
    assign gpr_wdata = result;

    always_comb begin
        csr_write.en    = done && ctrl_r.csr_op != csr_none;
        csr_write.sel   = ctrl_r.csr_sel;
        csr_write.data  = (ctrl_r.csr_op == csr_rs) ?
                          (ops_r.csr_rdata | ops_r.src1) : ops_r.src1;
        csr_write.ecall = done && ctrl_r.ecall;
        csr_write.epc   = pc_r;
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            pc_r   <= pc;
            ctrl_r <= ctrl;
            ops_r  <= ops;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= exu_idle;
            exu_valid <= 1'b0;
            lsu_req   <= '0;
            dnpc      <= reset_pc;
            halt      <= 1'b0;
            illegal   <= 1'b0;
        end else if (done) begin
            state                  <= exu_idle;
            exu_valid              <= 1'b1;
            dnpc                   <= next_pc;
            halt                   <= ctrl_r.ebreak;
            illegal                <= ctrl_r.illegal;
            lsu_req.addr_or_result <= result;
            lsu_req.store_data     <= ctrl_r.mem_store ? ops_r.src2 : '0;
            lsu_req.load           <= ctrl_r.mem_load;
            lsu_req.store          <= ctrl_r.mem_store;
            lsu_req.size           <= ctrl_r.mem_size;
            lsu_req.rd             <= ctrl_r.rd_we ? ctrl_r.rd : '0;
        end else begin
            exu_valid <= 1'b0;
            if (in_valid && in_ready) begin
                state <= exu_busy;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) exu_valid |=> !exu_valid);
    assert property (@(posedge clk) disable iff (rst) (in_valid && in_ready) |=> !in_ready);
    assert property (@(posedge clk) disable iff (rst) !(lsu_req.load && lsu_req.store));

endmodule

`default_nettype wire

//--- hw/gpr_file.sv
`timescale 1ns/1ns
`default_nettype none

module gpr_file
    import exec_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output xlen_t    rdata1,
    output xlen_t    rdata2,
    input  logic     exu_we,
    input  reg_idx_t exu_waddr,
    input  xlen_t    exu_wdata,
    input  logic     wb_we,
    input  reg_idx_t wb_waddr,
    input  xlen_t    wb_wdata
);

    xlen_t regs [32];

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    // the load write comes last so it wins on a shared address
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs <= '{default: '0};
        end else begin
            if (exu_we && exu_waddr != '0) begin
                regs[exu_waddr] <= exu_wdata;
            end
            if (wb_we && wb_waddr != '0) begin
                regs[wb_waddr] <= wb_wdata;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) (rs1 == '0) |-> (rdata1 == '0));

endmodule

`default_nettype wire

//--- hw/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module inst_decoder
    import exec_pkg::*;
(
    input  inst_t     inst,
    output exu_ctrl_t ctrl,
    output reg_idx_t  rs1,
    output reg_idx_t  rs2
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       bad;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        ctrl    = '0;
        ctrl.rd = inst[11:7];
        bad     = 1'b0;
        case (opcode)
            7'b0110111: begin
                ctrl.imm         = {inst[31:12], 12'b0};
                ctrl.alu_op      = alu_lui_pass;
                ctrl.src2_is_imm = 1'b1;
                ctrl.rd_we       = 1'b1;
            end
            7'b0010111: begin
                ctrl.imm         = {inst[31:12], 12'b0};
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.rd_we       = 1'b1;
            end
            7'b1101111: begin
                ctrl.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.is_jump     = 1'b1;
                ctrl.rd_we       = 1'b1;
            end
            7'b1100111: begin
                ctrl.imm         = {{20{inst[31]}}, inst[31:20]};
                ctrl.src2_is_imm = 1'b1;
                ctrl.is_jump     = 1'b1;
                ctrl.rd_we       = 1'b1;
                bad              = funct3 != 3'b000;
            end
            7'b1100011: begin
                // result is pc plus offset, cond decides whether it is taken
                ctrl.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.is_branch   = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = alu_beq;
                    3'b001:  ctrl.alu_op = alu_bne;
                    3'b100:  ctrl.alu_op = alu_blt;
                    3'b101:  ctrl.alu_op = alu_bge;
                    3'b110:  ctrl.alu_op = alu_bltu;
                    3'b111:  ctrl.alu_op = alu_bgeu;
                    default: bad = 1'b1;
                endcase
            end
            7'b0000011: begin
                ctrl.imm         = {{20{inst[31]}}, inst[31:20]};
                ctrl.src2_is_imm = 1'b1;
                ctrl.mem_load    = 1'b1;
                ctrl.rd_we       = 1'b1;
                case (funct3)
                    3'b000, 3'b100: ctrl.mem_size = mem_byte;
                    3'b001, 3'b101: ctrl.mem_size = mem_half;
                    3'b010:         ctrl.mem_size = mem_word;
                    default:        bad = 1'b1;
                endcase
            end
            7'b0100011: begin
                ctrl.imm         = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                ctrl.src2_is_imm = 1'b1;
                ctrl.mem_store   = 1'b1;
                ctrl.mem_size    = mem_size_e'(funct3[1:0]);
                bad              = funct3 > 3'b010;
            end
            7'b0010011, 7'b0110011: begin
                ctrl.imm         = {{20{inst[31]}}, inst[31:20]};
                ctrl.src2_is_imm = !opcode[5];
                ctrl.rd_we       = 1'b1;
                case (funct3)
                    3'b000: ctrl.alu_op = (opcode[5] && funct7[5]) ? alu_sub : alu_add;
                    3'b001: ctrl.alu_op = alu_sll;
                    3'b010: ctrl.alu_op = alu_slt;
                    3'b011: ctrl.alu_op = alu_sltu;
                    3'b100: ctrl.alu_op = alu_xor;
                    3'b101: ctrl.alu_op = funct7[5] ? alu_sra : alu_srl;
                    3'b110: ctrl.alu_op = alu_or;
                    default: ctrl.alu_op = alu_and;
                endcase
                // funct7 is only checked where it is not part of the immediate
                if (opcode[5] || funct3[1:0] == 2'b01) begin
                    bad = !(funct7 == 7'h00 ||
                            (funct7 == 7'h20 && (funct3 == 3'b101 ||
                                                 (opcode[5] && funct3 == 3'b000))));
                end
            end
            7'b1110011: begin
                ctrl.csr_sel = (inst[31:20] == 12'h341) ? csr_mepc : csr_mtvec;
                if (inst == 32'h0000_0073) begin
                    ctrl.ecall = 1'b1;
                end else if (inst == 32'h0010_0073) begin
                    ctrl.ebreak = 1'b1;
                end else if (inst == 32'h3020_0073) begin
                    ctrl.mret = 1'b1;
                end else if ((funct3 == 3'b001 || funct3 == 3'b010) &&
                             (inst[31:20] == 12'h305 || inst[31:20] == 12'h341)) begin
                    ctrl.csr_op = funct3[1] ? csr_rs : csr_rw;
                    ctrl.rd_we  = 1'b1;
                end else begin
                    bad = 1'b1;
                end
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            ctrl         = '0;
            ctrl.illegal = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the execute unit testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module exec_top_tb \
    -f exec_top.f \
    --Mdir obj_dir

./obj_dir/Vexec_top_tb

//--- include/exec_tb_vectors.svh
`ifndef EXEC_TB_VECTORS_SVH
`define EXEC_TB_VECTORS_SVH

// registers loaded through the writeback port before the table runs
localparam int num_preload = 4;
localparam reg_idx_t preload_rd [num_preload] = '{5'd1, 5'd2, 5'd3, 5'd4};
localparam xlen_t preload_data [num_preload] = '{
    32'h0000_0010, 32'h0000_0003, 32'hffff_fff0, 32'h8000_0100
};

// lsu_delay is the most cycles lsu_ready may stay low for that row
typedef struct packed {
    inst_t      inst;
    xlen_t      pc;
    logic [3:0] lsu_delay;
    lsu_req_t   req;
    xlen_t      dnpc;
    logic       halt;
    logic       illegal;
} tb_vec_t;

localparam int num_vecs = 33;
localparam tb_vec_t vectors [num_vecs] = '{
    '{32'h002082b3, 32'h100, 4'd0, '{32'h13, 0, 0, 0, mem_byte, 5}, 32'h104, 0, 0},
    '{32'h40208333, 32'h104, 4'd1, '{32'hd, 0, 0, 0, mem_byte, 6}, 32'h108, 0, 0},
    '{32'h002093b3, 32'h108, 4'd0, '{32'h80, 0, 0, 0, mem_byte, 7}, 32'h10c, 0, 0},
    '{32'h0011a433, 32'h10c, 4'd2, '{32'h1, 0, 0, 0, mem_byte, 8}, 32'h110, 0, 0},
    '{32'h0011b4b3, 32'h110, 4'd0, '{32'h0, 0, 0, 0, mem_byte, 9}, 32'h114, 0, 0},
    '{32'h0020c533, 32'h114, 4'd1, '{32'h13, 0, 0, 0, mem_byte, 10}, 32'h118, 0, 0},
    '{32'h0021d5b3, 32'h118, 4'd0, '{32'h1fff_fffe, 0, 0, 0, mem_byte, 11}, 32'h11c, 0, 0},
    '{32'h4021d633, 32'h11c, 4'd3, '{32'hffff_fffe, 0, 0, 0, mem_byte, 12}, 32'h120, 0, 0},
    '{32'h0020e6b3, 32'h120, 4'd0, '{32'h13, 0, 0, 0, mem_byte, 13}, 32'h124, 0, 0},
    '{32'h0011f733, 32'h124, 4'd1, '{32'h10, 0, 0, 0, mem_byte, 14}, 32'h128, 0, 0},
    '{32'hfff28793, 32'h128, 4'd0, '{32'h12, 0, 0, 0, mem_byte, 15}, 32'h12c, 0, 0},
    '{32'h4041d813, 32'h12c, 4'd2, '{32'hffff_ffff, 0, 0, 0, mem_byte, 16}, 32'h130, 0, 0},
    '{32'h123458b7, 32'h130, 4'd0, '{32'h1234_5000, 0, 0, 0, mem_byte, 17}, 32'h134, 0, 0},
    '{32'h00001917, 32'h134, 4'd1, '{32'h1134, 0, 0, 0, mem_byte, 18}, 32'h138, 0, 0},
    '{32'h00108463, 32'h138, 4'd0, '{32'h140, 0, 0, 0, mem_byte, 0}, 32'h140, 0, 0},
    '{32'h00109463, 32'h13c, 4'd1, '{32'h144, 0, 0, 0, mem_byte, 0}, 32'h140, 0, 0},
    '{32'h0011c463, 32'h140, 4'd0, '{32'h148, 0, 0, 0, mem_byte, 0}, 32'h148, 0, 0},
    '{32'h0011e463, 32'h144, 4'd2, '{32'h14c, 0, 0, 0, mem_byte, 0}, 32'h148, 0, 0},
    '{32'h0030d463, 32'h148, 4'd0, '{32'h150, 0, 0, 0, mem_byte, 0}, 32'h150, 0, 0},
    '{32'h0030f463, 32'h14c, 4'd1, '{32'h154, 0, 0, 0, mem_byte, 0}, 32'h150, 0, 0},
    '{32'h010009ef, 32'h150, 4'd0, '{32'h154, 0, 0, 0, mem_byte, 19}, 32'h160, 0, 0},
    '{32'h00520a67, 32'h154, 4'd1, '{32'h158, 0, 0, 0, mem_byte, 20}, 32'h8000_0104, 0, 0},
    '{32'h00822a83, 32'h158, 4'd0, '{32'h8000_0108, 0, 1, 0, mem_word, 21}, 32'h15c, 0, 0},
    '{32'hfff24b03, 32'h15c, 4'd2, '{32'h8000_00ff, 0, 1, 0, mem_byte, 22}, 32'h160, 0, 0},
    '{32'h00221223, 32'h160, 4'd0, '{32'h8000_0104, 3, 0, 1, mem_half, 0}, 32'h164, 0, 0},
    '{32'h00522023, 32'h164, 4'd6, '{32'h8000_0100, 32'h13, 0, 1, mem_word, 0}, 32'h168, 0, 0},
    '{32'h30521bf3, 32'h168, 4'd0, '{32'h0, 0, 0, 0, mem_byte, 23}, 32'h16c, 0, 0},
    '{32'h30502c73, 32'h16c, 4'd1, '{32'h8000_0100, 0, 0, 0, mem_byte, 24}, 32'h170, 0, 0},
    '{32'h00000073, 32'h170, 4'd0, '{32'h0, 0, 0, 0, mem_byte, 0}, 32'h8000_0100, 0, 0},
    '{32'h34102cf3, 32'h174, 4'd1, '{32'h170, 0, 0, 0, mem_byte, 25}, 32'h178, 0, 0},
    '{32'h30200073, 32'h178, 4'd0, '{32'h3, 0, 0, 0, mem_byte, 0}, 32'h170, 0, 0},
    '{32'h00100073, 32'h17c, 4'd1, '{32'h10, 0, 0, 0, mem_byte, 0}, 32'h180, 1, 0},
    '{32'hffffffff, 32'h180, 4'd0, '{32'h0, 0, 0, 0, mem_byte, 0}, 32'h184, 0, 1}
};

`endif

//--- testbench/exec_top_tb.sv
`timescale 1ns/1ns
`default_nettype none

module exec_top_tb
    import exec_pkg::*;
();

    `include "exec_tb_vectors.svh"

    logic     clk;
    logic     rst;
    logic     in_valid;
    logic     in_ready;
    inst_t    inst;
    xlen_t    pc;
    logic     lsu_ready;
    logic     wb_valid;
    reg_idx_t wb_rd;
    xlen_t    wb_data;
    logic     exu_valid;
    lsu_req_t lsu_req;
    xlen_t    dnpc;
    logic     halt;
    logic     illegal;

    int seed;
    int cycle_count;
    int cycle_limit;

    exec_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .inst      (inst),
        .pc        (pc),
        .lsu_ready (lsu_ready),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .exu_valid (exu_valid),
        .lsu_req   (lsu_req),
        .dnpc      (dnpc),
        .halt      (halt),
        .illegal   (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("run exceeded its limit of %0d cycles", cycle_limit);
            $display("** FAIL **");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            $display("** FAIL **");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_req(input string name, input lsu_req_t got, input lsu_req_t exp);
        if (got !== exp) begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            $display("** FAIL **");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            $display("** FAIL **");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    function automatic int max_table_delay();
        int m;
        m = 0;
        for (int k = 0; k < num_vecs; k++) begin
            if (int'(vectors[k].lsu_delay) > m) begin
                m = int'(vectors[k].lsu_delay);
            end
        end
        return m;
    endfunction

    task automatic write_reg(input reg_idx_t rd, input xlen_t data);
        wb_valid = 1'b1;
        wb_rd    = rd;
        wb_data  = data;
        @(negedge clk);
        wb_valid = 1'b0;
    endtask

    // called at a falling edge while the execute unit is idle
    task automatic run_row(input int idx, input tb_vec_t v, input int delay);
        lsu_req_t held_req;
        xlen_t    held_dnpc;
        logic     held_halt;
        logic     held_illegal;
        int       waited;
        check_flag("in_ready", in_ready, 1'b1);
        held_req     = lsu_req;
        held_dnpc    = dnpc;
        held_halt    = halt;
        held_illegal = illegal;
        inst      = v.inst;
        pc        = v.pc;
        in_valid  = 1'b1;
        lsu_ready = (delay == 0);
        @(negedge clk);
        in_valid = 1'b0;
        // exu_valid of the previous row lasts one cycle
        check_flag("exu_valid", exu_valid, 1'b0);
        check_flag("in_ready", in_ready, 1'b0);
        // busy with lsu_ready low must leave every output untouched
        for (int k = 0; k < delay; k++) begin
            check_flag("exu_valid", exu_valid, 1'b0);
            check_flag("in_ready", in_ready, 1'b0);
            check_req("lsu_req", lsu_req, held_req);
            check_word("dnpc", dnpc, held_dnpc);
            check_flag("halt", halt, held_halt);
            check_flag("illegal", illegal, held_illegal);
            @(negedge clk);
        end
        lsu_ready = 1'b1;
        waited = 0;
        while (!exu_valid) begin
            if (waited >= 4) begin
                $display("row %0d never raised exu_valid after lsu_ready", idx);
                $display("** FAIL **");
                $fatal(1, "exu_valid missing");
            end
            @(negedge clk);
            waited++;
        end
        check_req("lsu_req", lsu_req, v.req);
        check_word("dnpc", dnpc, v.dnpc);
        check_flag("halt", halt, v.halt);
        check_flag("illegal", illegal, v.illegal);
    endtask

    initial begin
        logic [31:0] r;
        int          delay;
        tb_vec_t     wb_row;
        xlen_t       wb_value;
        seed        = 32'hf8cb7683;
        cycle_count = 0;
        cycle_limit = (num_vecs + 1) * (4 + max_table_delay()) + 2 * num_preload + 40;
        rst       = 1'b1;
        in_valid  = 1'b0;
        inst      = '0;
        pc        = '0;
        lsu_ready = 1'b0;
        wb_valid  = 1'b0;
        wb_rd     = '0;
        wb_data   = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_flag("in_ready", in_ready, 1'b1);
        check_flag("exu_valid", exu_valid, 1'b0);
        check_flag("halt", halt, 1'b0);
        check_flag("illegal", illegal, 1'b0);
        check_req("lsu_req", lsu_req, '0);
        check_word("dnpc", dnpc, reset_pc);
        rst = 1'b0;
        @(negedge clk);
        for (int k = 0; k < num_preload; k++) begin
            write_reg(preload_rd[k], preload_data[k]);
        end
        // each row is offered in the cycle where the previous one shows exu_valid
        for (int k = 0; k < num_vecs; k++) begin
            r     = $random(seed);
            delay = int'(r % (32'(vectors[k].lsu_delay) + 32'd1));
            run_row(k, vectors[k], delay);
        end
        // a value placed by the load writeback port is read back by addi x27, x26, 0
        wb_value = $random(seed);
        write_reg(5'd26, wb_value);
        wb_row                    = '0;
        wb_row.inst               = 32'h000d0d93;
        wb_row.pc                 = 32'h0000_0200;
        wb_row.req.addr_or_result = wb_value;
        wb_row.req.rd             = 5'd27;
        wb_row.dnpc               = 32'h0000_0204;
        run_row(num_vecs, wb_row, 5);
        lsu_ready = 1'b0;
        @(negedge clk);
        check_flag("exu_valid", exu_valid, 1'b0);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire
